// File: Bender.yml
package:
  name: shader_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/shader_core_pkg.sv
      - hdl/register_file.sv
      - hdl/instruction_decoder.sv
      - hdl/alu.sv
      - hdl/shader_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_ram.sv
      - verif/shader_core_tb.sv

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "shader_core_macros.svh"

module alu (
    input  logic                          clock,
    input  logic [`SC_WORD_WIDTH-1:0]     operand_a,
    input  logic [`SC_WORD_WIDTH-1:0]     operand_b,
    input  shader_core_pkg::alu_op_t      alu_op,
    input  logic [`SC_WORD_WIDTH-1:0]     compare_a,
    input  logic [`SC_WORD_WIDTH-1:0]     compare_b,
    input  logic [2:0]                    funct3,
    output logic [`SC_WORD_WIDTH-1:0]     result,
    output logic                          branch_taken
);

    // result follows the operands one clock later
    always_ff @(posedge clock) begin
        case (alu_op)
            shader_core_pkg::ADD:  result <= operand_a + operand_b;
            shader_core_pkg::SUB:  result <= operand_a - operand_b;
            shader_core_pkg::SLL:  result <= operand_a << operand_b[4:0];
            shader_core_pkg::SLT:  result <= {31'b0, $signed(operand_a) < $signed(operand_b)};
            shader_core_pkg::SLTU: result <= {31'b0, operand_a < operand_b};
            shader_core_pkg::XOR:  result <= operand_a ^ operand_b;
            shader_core_pkg::SRL:  result <= operand_a >> operand_b[4:0];
            shader_core_pkg::SRA:  result <= $signed(operand_a) >>> operand_b[4:0];
            shader_core_pkg::OR:   result <= operand_a | operand_b;
            shader_core_pkg::AND:  result <= operand_a & operand_b;
            default:               result <= '0;
        endcase
    end

    // branch condition straight from the register values
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (compare_a == compare_b);
            3'b001:  branch_taken = (compare_a != compare_b);
            3'b100:  branch_taken = ($signed(compare_a) < $signed(compare_b));
            3'b101:  branch_taken = ($signed(compare_a) >= $signed(compare_b));
            3'b110:  branch_taken = (compare_a < compare_b);
            3'b111:  branch_taken = (compare_a >= compare_b);
            default: branch_taken = 1'b0;
        endcase
    end

    // decoder masks shift amounts to five bits
    a_shift_in_range: assert property (
        @(posedge clock)
        (alu_op inside {shader_core_pkg::SLL, shader_core_pkg::SRL, shader_core_pkg::SRA})
        |-> (operand_b < 32)
    );

endmodule

// File: hdl/instruction_decoder.sv
`timescale 1ns/1ps
`include "shader_core_macros.svh"

module instruction_decoder (
    input  logic [`SC_WORD_WIDTH-1:0] instruction,
    input  logic [`SC_WORD_WIDTH-1:0] rs1_value,
    input  logic [`SC_WORD_WIDTH-1:0] rs2_value,
    input  logic [`SC_WORD_WIDTH-1:0] pc,
    output shader_core_pkg::decoded_t decoded
);

    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_ALU_REG = 7'b0110011;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic                      funct7_alt;
    logic                      is_shift;
    logic [`SC_WORD_WIDTH-1:0] imm_i;
    logic [`SC_WORD_WIDTH-1:0] imm_s;
    logic [`SC_WORD_WIDTH-1:0] imm_b;
    logic [`SC_WORD_WIDTH-1:0] imm_u;
    logic [`SC_WORD_WIDTH-1:0] imm_j;
    logic [`SC_WORD_WIDTH-1:0] shamt;
    logic [`SC_WORD_WIDTH-1:0] rs2_masked;
    shader_core_pkg::alu_op_t  funct_op;

    assign opcode     = instruction[6:0];
    assign funct3     = instruction[14:12];
    // bit 30 picks sub and sra
    assign funct7_alt = instruction[30];
    assign is_shift   = (funct3 == 3'b001) || (funct3 == 3'b101);

    // sign-extended immediates
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    assign shamt      = {27'b0, instruction[24:20]};
    assign rs2_masked = {27'b0, rs2_value[4:0]};

    // funct3 map shared by reg-imm and reg-reg
    always_comb begin
        case (funct3)
            3'b000:  funct_op = (opcode == OPC_ALU_REG && funct7_alt) ?
                                shader_core_pkg::SUB : shader_core_pkg::ADD;
            3'b001:  funct_op = shader_core_pkg::SLL;
            3'b010:  funct_op = shader_core_pkg::SLT;
            3'b011:  funct_op = shader_core_pkg::SLTU;
            3'b100:  funct_op = shader_core_pkg::XOR;
            3'b101:  funct_op = funct7_alt ? shader_core_pkg::SRA : shader_core_pkg::SRL;
            3'b110:  funct_op = shader_core_pkg::OR;
            default: funct_op = shader_core_pkg::AND;
        endcase
    end

    always_comb begin
        decoded.is_alu_imm = (opcode == OPC_ALU_IMM);
        decoded.is_alu_reg = (opcode == OPC_ALU_REG);
        decoded.is_lui     = (opcode == OPC_LUI);
        decoded.is_jal     = (opcode == OPC_JAL);
        decoded.is_jalr    = (opcode == OPC_JALR);
        decoded.is_branch  = (opcode == OPC_BRANCH);
        decoded.is_load    = (opcode == OPC_LOAD);
        decoded.is_store   = (opcode == OPC_STORE);
        decoded.is_halt    = (opcode == OPC_SYSTEM) && (instruction[31:20] == `SC_HALT_IMM);
        decoded.rs1        = instruction[19:15];
        decoded.rs2        = instruction[24:20];
        decoded.rd         = instruction[11:7];
        decoded.funct3     = funct3;

        // first operand
        if (decoded.is_alu_imm || decoded.is_alu_reg || decoded.is_load ||
            decoded.is_store || decoded.is_jalr) begin
            decoded.operand_a = rs1_value;
        end else if (decoded.is_lui) begin
            decoded.operand_a = imm_u;
        end else if (decoded.is_jal || decoded.is_branch) begin
            decoded.operand_a = pc;
        end else begin
            decoded.operand_a = '0;
        end

        // second operand
        if (decoded.is_alu_imm) begin
            decoded.operand_b = is_shift ? shamt : imm_i;
        end else if (decoded.is_alu_reg) begin
            decoded.operand_b = is_shift ? rs2_masked : rs2_value;
        end else if (decoded.is_load || decoded.is_jalr) begin
            decoded.operand_b = imm_i;
        end else if (decoded.is_store) begin
            decoded.operand_b = imm_s;
        end else if (decoded.is_branch) begin
            decoded.operand_b = imm_b;
        end else if (decoded.is_jal) begin
            decoded.operand_b = imm_j;
        end else begin
            decoded.operand_b = '0;
        end

        // address and target forms all add
        if (decoded.is_alu_imm || decoded.is_alu_reg) begin
            decoded.alu_op = funct_op;
        end else if (decoded.is_lui || decoded.is_jal || decoded.is_jalr ||
                     decoded.is_branch || decoded.is_load || decoded.is_store) begin
            decoded.alu_op = shader_core_pkg::ADD;
        end else begin
            decoded.alu_op = shader_core_pkg::NONE;
        end
    end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps
`include "shader_core_macros.svh"

module register_file (
    input  logic                          clock,
    input  logic                          write,
    input  logic [`SC_REG_ADDR_WIDTH-1:0] write_address,
    input  logic [`SC_WORD_WIDTH-1:0]     write_data,
    input  logic [`SC_REG_ADDR_WIDTH-1:0] read1_address,
    output logic [`SC_WORD_WIDTH-1:0]     read1_data,
    input  logic [`SC_REG_ADDR_WIDTH-1:0] read2_address,
    output logic [`SC_WORD_WIDTH-1:0]     read2_data
);

    logic [`SC_WORD_WIDTH-1:0] regs [0:(1 << `SC_REG_ADDR_WIDTH)-1];

    always_ff @(posedge clock) begin
        if (write) begin
            regs[write_address] <= write_data;
        end
    end

    // x0 reads as zero whatever the array holds
    assign read1_data = (read1_address == '0) ? '0 : regs[read1_address];
    assign read2_data = (read2_address == '0) ? '0 : regs[read2_address];

    // the core filters rd == 0 before it raises the write enable
    a_no_write_x0: assert property (
        @(posedge clock) write |-> (write_address != '0)
    );

endmodule

// File: hdl/shader_core.sv
`timescale 1ns/1ps
`include "shader_core_macros.svh"

module shader_core (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      run,
    output logic                      halted,
    output logic [`SC_ADDR_WIDTH-1:0] inst_ram_address,
    input  logic [`SC_WORD_WIDTH-1:0] inst_ram_read_result,
    output logic [`SC_ADDR_WIDTH-1:0] data_ram_address,
    output logic [`SC_WORD_WIDTH-1:0] data_ram_write_data,
    output logic                      data_ram_write,
    input  logic [`SC_WORD_WIDTH-1:0] data_ram_read_result
);

    shader_core_pkg::core_state_t state;
    shader_core_pkg::decoded_t    decoded;
    shader_core_pkg::data_req_t   data_req;

    logic [`SC_WORD_WIDTH-1:0] pc;
    logic [`SC_WORD_WIDTH-1:0] instruction;
    logic [`SC_WORD_WIDTH-1:0] rs1_value;
    logic [`SC_WORD_WIDTH-1:0] rs2_value;
    logic [`SC_WORD_WIDTH-1:0] alu_result;
    logic                      branch_taken;
    logic                      wb_write;
    logic [`SC_WORD_WIDTH-1:0] wb_data;
    logic                      writes_rd;

    register_file u_register_file (
        .clock         (clock),
        .write         (wb_write),
        .write_address (decoded.rd),
        .write_data    (wb_data),
        .read1_address (decoded.rs1),
        .read1_data    (rs1_value),
        .read2_address (decoded.rs2),
        .read2_data    (rs2_value)
    );

    instruction_decoder u_instruction_decoder (
        .instruction (instruction),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .pc          (pc),
        .decoded     (decoded)
    );

    alu u_alu (
        .clock        (clock),
        .operand_a    (decoded.operand_a),
        .operand_b    (decoded.operand_b),
        .alu_op       (decoded.alu_op),
        .compare_a    (rs1_value),
        .compare_b    (rs2_value),
        .funct3       (decoded.funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    assign writes_rd = decoded.is_alu_imm || decoded.is_alu_reg || decoded.is_lui ||
                       decoded.is_jal || decoded.is_jalr || decoded.is_load;

    assign data_ram_address    = data_req.address;
    assign data_ram_write_data = data_req.write_data;
    assign data_ram_write      = data_req.write;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= shader_core_pkg::INIT;
            pc             <= `SC_RESET_PC;
            halted         <= 1'b0;
            wb_write       <= 1'b0;
            data_req.write <= 1'b0;
        end else if (run) begin
            case (state)
                shader_core_pkg::INIT: begin
                    pc    <= `SC_RESET_PC;
                    state <= shader_core_pkg::FETCH;
                end
                shader_core_pkg::FETCH: begin
                    // previous write-back lands on this edge
                    wb_write         <= 1'b0;
                    inst_ram_address <= pc[`SC_ADDR_WIDTH-1:0];
                    state            <= shader_core_pkg::FETCH2;
                end
                shader_core_pkg::FETCH2: begin
                    state <= shader_core_pkg::DECODE;
                end
                shader_core_pkg::DECODE: begin
                    instruction <= inst_ram_read_result;
                    state       <= shader_core_pkg::REGISTERS;
                end
                shader_core_pkg::REGISTERS: begin
                    if (decoded.is_halt) begin
                        halted <= 1'b1;
                    end
                    state <= shader_core_pkg::ALU;
                end
                shader_core_pkg::ALU: begin
                    if (halted) begin
                        state <= shader_core_pkg::HALTED;
                    end else if (decoded.is_load) begin
                        state <= shader_core_pkg::LOAD;
                    end else if (decoded.is_store) begin
                        state <= shader_core_pkg::STORE;
                    end else begin
                        state <= shader_core_pkg::RETIRE;
                    end
                end
                shader_core_pkg::LOAD: begin
                    data_req.address <= alu_result[`SC_ADDR_WIDTH-1:0];
                    state            <= shader_core_pkg::LOAD2;
                end
                shader_core_pkg::LOAD2: begin
                    state <= shader_core_pkg::RETIRE;
                end
                shader_core_pkg::STORE: begin
                    // write strobe is seen during RETIRE only
                    data_req.address    <= alu_result[`SC_ADDR_WIDTH-1:0];
                    data_req.write_data <= rs2_value;
                    data_req.write      <= 1'b1;
                    state               <= shader_core_pkg::RETIRE;
                end
                shader_core_pkg::RETIRE: begin
                    data_req.write <= 1'b0;
                    wb_write       <= writes_rd && (decoded.rd != '0);
                    if (decoded.is_jal || decoded.is_jalr) begin
                        wb_data <= pc + `SC_PC_STEP;
                    end else if (decoded.is_load) begin
                        wb_data <= data_ram_read_result;
                    end else begin
                        wb_data <= alu_result;
                    end
                    // jump targets lose bit 0
                    if (decoded.is_jal || decoded.is_jalr) begin
                        pc <= {alu_result[`SC_WORD_WIDTH-1:1], 1'b0};
                    end else if (decoded.is_branch && branch_taken) begin
                        pc <= alu_result;
                    end else begin
                        pc <= pc + `SC_PC_STEP;
                    end
                    state <= shader_core_pkg::FETCH;
                end
                shader_core_pkg::HALTED: begin
                    state <= shader_core_pkg::HALTED;
                end
                default: begin
                    state <= shader_core_pkg::INIT;
                end
            endcase
        end
    end

    a_write_only_in_retire: assert property (
        @(posedge clock) disable iff (!reset_n)
        data_ram_write |-> (state == shader_core_pkg::RETIRE)
    );

    // a halted core never goes back to fetching
    a_halt_sticky: assert property (
        @(posedge clock) disable iff (!reset_n)
        halted |=> halted && (state inside {shader_core_pkg::ALU, shader_core_pkg::HALTED})
    );

endmodule

// File: hdl/shader_core_macros.svh
`ifndef SHADER_CORE_MACROS_SVH
`define SHADER_CORE_MACROS_SVH

// data and instruction word width
`define SC_WORD_WIDTH 32

// address width of both external RAMs
`define SC_ADDR_WIDTH 16

// register index width
`define SC_REG_ADDR_WIDTH 5

// pc after reset, and bytes per instruction
`define SC_RESET_PC 32'h0000_0000
`define SC_PC_STEP 32'd4

// system immediate that stops the core
`define SC_HALT_IMM 12'd1

`endif

// File: hdl/shader_core_pkg.sv
`include "shader_core_macros.svh"

package shader_core_pkg;

    // control states of the multicycle core
    typedef enum logic [3:0] {
        INIT,
        FETCH,
        FETCH2,
        DECODE,
        REGISTERS,
        ALU,
        LOAD,
        LOAD2,
        STORE,
        RETIRE,
        HALTED
    } core_state_t;

    // operators understood by the alu
    typedef enum logic [3:0] {
        NONE,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_t;

    // everything the core needs from one instruction
    typedef struct packed {
        logic                          is_alu_imm;
        logic                          is_alu_reg;
        logic                          is_lui;
        logic                          is_jal;
        logic                          is_jalr;
        logic                          is_branch;
        logic                          is_load;
        logic                          is_store;
        logic                          is_halt;
        logic [`SC_REG_ADDR_WIDTH-1:0] rs1;
        logic [`SC_REG_ADDR_WIDTH-1:0] rs2;
        logic [`SC_REG_ADDR_WIDTH-1:0] rd;
        logic [2:0]                    funct3;
        alu_op_t                       alu_op;
        logic [`SC_WORD_WIDTH-1:0]     operand_a;
        logic [`SC_WORD_WIDTH-1:0]     operand_b;
    } decoded_t;

    // request towards the data RAM
    typedef struct packed {
        logic [`SC_ADDR_WIDTH-1:0] address;
        logic [`SC_WORD_WIDTH-1:0] write_data;
        logic                      write;
    } data_req_t;

endpackage

// File: project.f
+incdir+hdl
hdl/shader_core_pkg.sv
hdl/register_file.sv
hdl/instruction_decoder.sv
hdl/alu.sv
hdl/shader_core.sv
verif/tb_ram.sv
verif/shader_core_tb.sv

// File: verif/shader_core_tb.sv
`timescale 1ns/1ps
`include "shader_core_macros.svh"

module shader_core_tb;

    localparam int CLOCK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 50;
    localparam int PROG_WORDS   = 12;
    localparam int MAX_TESTS    = 48;
    // twelve instructions of at most eight cycles plus reset and the hold after halt
    localparam int CYCLES_PER_TEST = PROG_WORDS * 8 + RESET_CYCLES + HOLD_CYCLES + 2;

    localparam logic [6:0]  OP_IMM         = 7'b0010011;
    localparam logic [6:0]  OP_LOAD        = 7'b0000011;
    localparam logic [6:0]  OP_JALR        = 7'b1100111;
    localparam logic [31:0] HALT           = 32'h0010_0073;
    localparam logic [11:0] TAKEN_MARK     = 12'h5a5;
    localparam logic [11:0] NOT_TAKEN_MARK = 12'h0c3;
    localparam logic [11:0] LOAD_SLOT      = 12'h7f0;

    typedef struct packed {
        logic [PROG_WORDS-1:0][`SC_WORD_WIDTH-1:0] words;
        logic [31:0]                               store_address;
        logic [31:0]                               store_data;
        logic [31:0]                               store_count;
        logic [31:0]                               halt_address;
    } test_entry_t;

    logic                      clock;
    logic                      reset_n;
    logic                      run;
    logic                      halted;
    logic [`SC_ADDR_WIDTH-1:0] inst_ram_address;
    logic [`SC_WORD_WIDTH-1:0] inst_ram_read_result;
    logic [`SC_ADDR_WIDTH-1:0] data_ram_address;
    logic [`SC_WORD_WIDTH-1:0] data_ram_write_data;
    logic                      data_ram_write;
    logic [`SC_WORD_WIDTH-1:0] data_ram_read_result;

    test_entry_t tests [0:MAX_TESTS-1];
    test_entry_t entry;
    int          n_tests = 0;
    int          n_words = 0;
    // word index of the halt that ends the program
    int          halt_word = -1;
    int          current_test = 0;
    int          checks = 0;
    int          errors = 0;
    logic        table_ready = 1'b0;
    logic [31:0] lcg_state = 32'h44be_abf2;
    logic [31:0] store_address [$];
    logic [31:0] store_data [$];

    shader_core u_dut (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .halted               (halted),
        .inst_ram_address     (inst_ram_address),
        .inst_ram_read_result (inst_ram_read_result),
        .data_ram_address     (data_ram_address),
        .data_ram_write_data  (data_ram_write_data),
        .data_ram_write       (data_ram_write),
        .data_ram_read_result (data_ram_read_result)
    );

    tb_ram u_inst_ram (
        .clock      (clock),
        .address    (inst_ram_address),
        .write_data ('0),
        .write      (1'b0),
        .read_data  (inst_ram_read_result)
    );

    tb_ram u_data_ram (
        .clock      (clock),
        .address    (data_ram_address),
        .write_data (data_ram_write_data),
        .write      (data_ram_write),
        .read_data  (data_ram_read_result)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // RV32I encodings
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    // always a sw
    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] offset, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {offset[12], offset[10:5], rs2, rs1, f3, offset[4:1], offset[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lui_instr(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] jal_instr(input logic [20:0] offset, input logic [4:0] rd);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
    endfunction

    // expected results from the RV32I operation rules
    function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [11:0] next_slot();
        return 12'h200 + n_tests[11:0] * 12'd4;
    endfunction

    task automatic append_word(input logic [31:0] word);
        entry.words[n_words] = word;
        n_words++;
    endtask

    // lui then addi with the upper part absorbing the sign of the low twelve bits
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        append_word(lui_instr(upper[31:12], rd));
        append_word(i_type(value[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic finish_program(input logic [11:0] slot, input logic [31:0] data,
                                  input logic [31:0] count);
        if (halt_word < 0) begin
            halt_word = n_words;
        end
        append_word(HALT);
        while (n_words < PROG_WORDS) begin
            append_word(HALT);
        end
        entry.store_address = {20'b0, slot};
        entry.store_data    = data;
        entry.store_count   = count;
        entry.halt_address  = halt_word * 4;
        tests[n_tests]      = entry;
        n_tests++;
        n_words   = 0;
        halt_word = -1;
    endtask

    task automatic imm_case(input logic [2:0] f3, input logic alt);
        logic [31:0] a;
        logic [31:0] r;
        logic [11:0] imm;
        logic [11:0] slot;
        a = next_random();
        r = next_random();
        imm = r[11:0];
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm = {1'b0, alt, 5'b0, r[4:0]};
        end
        slot = next_slot();
        load_const(5'd1, a);
        append_word(i_type(imm, 5'd1, f3, 5'd3, OP_IMM));
        append_word(s_type(slot, 5'd3, 5'd0));
        finish_program(slot, alu_rule(f3, alt, a, {{20{imm[11]}}, imm}), 32'd1);
    endtask

    task automatic reg_case(input logic [2:0] f3, input logic alt, input logic [31:0] a,
                            input logic [31:0] b, input logic [4:0] rd);
        logic [11:0] slot;
        slot = next_slot();
        load_const(5'd1, a);
        load_const(5'd2, b);
        append_word(r_type(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, rd));
        append_word(s_type(slot, rd, 5'd0));
        // x0 reads back as zero
        finish_program(slot, (rd == 5'd0) ? 32'd0 : alu_rule(f3, alt, a, b), 32'd1);
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [31:0] a,
                               input logic [31:0] b);
        logic [11:0] slot;
        slot = next_slot();
        load_const(5'd1, a);
        load_const(5'd2, b);
        append_word(b_type(13'd12, 5'd2, 5'd1, f3));
        append_word(i_type(NOT_TAKEN_MARK, 5'd0, 3'b000, 5'd3, OP_IMM));
        append_word(jal_instr(21'd8, 5'd0));
        append_word(i_type(TAKEN_MARK, 5'd0, 3'b000, 5'd3, OP_IMM));
        append_word(s_type(slot, 5'd3, 5'd0));
        finish_program(slot, {20'b0, branch_rule(f3, a, b) ? TAKEN_MARK : NOT_TAKEN_MARK},
                       32'd1);
    endtask

    task automatic jump_cases();
        logic [11:0] slot;
        // jal at 0 skips a store and links 4
        slot = next_slot();
        append_word(jal_instr(21'd12, 5'd1));
        append_word(s_type(slot, 5'd0, 5'd0));
        append_word(HALT);
        append_word(s_type(slot, 5'd1, 5'd0));
        finish_program(slot, 32'd4, 32'd1);
        // jalr at 4 targets 13 + 4 and lands on 16 once bit 0 is dropped
        // a jal at the target exposes the pc through its link
        slot = next_slot();
        append_word(i_type(12'd13, 5'd0, 3'b000, 5'd2, OP_IMM));
        append_word(i_type(12'd4, 5'd2, 3'b000, 5'd1, OP_JALR));
        append_word(s_type(slot, 5'd0, 5'd0));
        append_word(HALT);
        append_word(jal_instr(21'd8, 5'd5));
        append_word(HALT);
        append_word(r_type(7'b0000000, 5'd5, 5'd1, 3'b000, 5'd6));
        append_word(s_type(slot, 5'd6, 5'd0));
        finish_program(slot, 32'd8 + 32'd20, 32'd1);
    endtask

    task automatic memory_case();
        logic [31:0] value;
        logic [11:0] slot;
        value = next_random();
        slot = next_slot();
        load_const(5'd1, value);
        append_word(s_type(LOAD_SLOT, 5'd1, 5'd0));
        append_word(i_type(LOAD_SLOT, 5'd0, 3'b010, 5'd4, OP_LOAD));
        append_word(s_type(slot, 5'd4, 5'd0));
        finish_program(slot, value, 32'd2);
    endtask

    task automatic halt_case();
        logic [31:0] value;
        logic [11:0] slot;
        value = next_random();
        slot = next_slot();
        load_const(5'd1, value);
        append_word(s_type(slot, 5'd1, 5'd0));
        halt_word = n_words;
        append_word(HALT);
        // never reached
        append_word(s_type(slot + 12'd4, 5'd1, 5'd0));
        finish_program(slot, value, 32'd1);
    endtask

    task automatic build_table();
        logic [31:0] x;
        logic [31:0] neg;
        logic [31:0] pos;
        logic [2:0]  f3;
        entry = '0;
        for (int f = 0; f < 8; f++) begin
            f3 = f[2:0];
            imm_case(f3, 1'b0);
        end
        imm_case(3'b101, 1'b1);
        // negative first operand separates slt from sltu
        for (int f = 0; f < 8; f++) begin
            f3 = f[2:0];
            neg = next_random() | 32'h8000_0000;
            pos = next_random() & 32'h7fff_ffff;
            reg_case(f3, 1'b0, neg, pos, 5'd3);
        end
        reg_case(3'b000, 1'b1, next_random(), next_random(), 5'd3);
        reg_case(3'b101, 1'b1, next_random() | 32'h8000_0000, next_random(), 5'd3);
        reg_case(3'b000, 1'b0, next_random(), next_random(), 5'd0);
        memory_case();
        // equal, negative against positive, positive against negative
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                f3 = f[2:0];
                x = next_random();
                neg = next_random() | 32'h8000_0000;
                pos = next_random() & 32'h7fff_ffff;
                branch_case(f3, x, x);
                branch_case(f3, neg, pos);
                branch_case(f3, pos, neg);
            end
        end
        jump_cases();
        halt_case();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Fail %s in test %0d: got %h, expected %h",
                     name, current_test, actual, expected);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        current_test = t;
        @(posedge clock);
        reset_n <= 1'b0;
        run     <= 1'b0;
        for (int w = 0; w < PROG_WORDS; w++) begin
            u_inst_ram.mem[w] = tests[t].words[w];
        end
        repeat (RESET_CYCLES) @(posedge clock);
        check_value("halted", {31'b0, halted}, 32'd0);
        check_value("data_ram_write", {31'b0, data_ram_write}, 32'd0);
        store_address.delete();
        store_data.delete();
        reset_n <= 1'b1;
        run     <= 1'b1;
        do begin
            @(posedge clock);
        end while (halted !== 1'b1);
        // run stays high and the core must not move again
        repeat (HOLD_CYCLES) begin
            @(posedge clock);
            check_value("halted", {31'b0, halted}, 32'd1);
            check_value("inst_ram_address", 32'(inst_ram_address), tests[t].halt_address);
        end
        @(negedge clock);
        check_value("data_ram_write pulses", store_address.size(), tests[t].store_count);
        if (store_address.size() > 0) begin
            check_value("data_ram_address", store_address[$], tests[t].store_address);
            check_value("data_ram_write_data", store_data[$], tests[t].store_data);
        end
    endtask

    // every store pulse seen at the ports
    always @(posedge clock) begin
        if (data_ram_write === 1'b1) begin
            store_address.push_back(32'(data_ram_address));
            store_data.push_back(data_ram_write_data);
        end
    end

    initial begin
        reset_n = 1'b0;
        run     = 1'b0;
        build_table();
        table_ready = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(n_tests * CYCLES_PER_TEST * CLOCK_PERIOD);
        $display("Timeout: the core did not work through the program table in time");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verif/tb_ram.sv
`timescale 1ns/1ps
`include "shader_core_macros.svh"

module tb_ram (
    input  logic                      clock,
    input  logic [`SC_ADDR_WIDTH-1:0] address,
    input  logic [`SC_WORD_WIDTH-1:0] write_data,
    input  logic                      write,
    output logic [`SC_WORD_WIDTH-1:0] read_data
);

    // word addressed, byte address bits 1:0 are ignored
    localparam int DEPTH = 1 << (`SC_ADDR_WIDTH - 2);

    logic [`SC_WORD_WIDTH-1:0] mem [0:DEPTH-1];

    initial begin : fill
        logic [`SC_ADDR_WIDTH-1:0] byte_address;
        read_data = '0;
        // pattern built from the full byte address of each word
        for (int i = 0; i < DEPTH; i++) begin
            byte_address = `SC_ADDR_WIDTH'(i << 2);
            mem[i] = {~byte_address, byte_address};
        end
    end

    // read data shows up one cycle after the address
    always @(posedge clock) begin
        if (write) begin
            mem[address[`SC_ADDR_WIDTH-1:2]] <= write_data;
        end
        read_data <= mem[address[`SC_ADDR_WIDTH-1:2]];
    end

endmodule
